// File: common/id_pkg.sv
package id_pkg;

	localparam int data_w = 32;
	localparam int reg_addr_w = 5;
	localparam int op_w = 6;
	localparam int aluop_w = 8;
	localparam int alusel_w = 3;

	typedef logic [data_w-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	localparam reg_addr_t link_reg = reg_addr_t'(31);   // $ra

	// primary opcode, inst[31:26]
	typedef enum logic [op_w-1:0] {
		OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001,
		OP_J       = 6'b000010, OP_JAL    = 6'b000011,
		OP_BEQ     = 6'b000100, OP_BNE    = 6'b000101,
		OP_BLEZ    = 6'b000110, OP_BGTZ   = 6'b000111,
		OP_ADDI    = 6'b001000, OP_ADDIU  = 6'b001001,
		OP_SLTI    = 6'b001010, OP_SLTIU  = 6'b001011,
		OP_ANDI    = 6'b001100, OP_ORI    = 6'b001101,
		OP_XORI    = 6'b001110, OP_LUI    = 6'b001111,
		OP_LW      = 6'b100011, OP_SW     = 6'b101011
	} opcode_e;

	// SPECIAL function field, inst[5:0]
	typedef enum logic [op_w-1:0] {
		FN_SLL  = 6'b000000, FN_SRL  = 6'b000010, FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100, FN_SRLV = 6'b000110, FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000, FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000, FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010, FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100, FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110, FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010, FN_SLTU = 6'b101011
	} funct_e;

	typedef enum logic [aluop_w-1:0] {
		ALU_NOP  = 8'b00000000,
		ALU_AND  = 8'b00100100, ALU_OR   = 8'b00100101,
		ALU_XOR  = 8'b00100110, ALU_NOR  = 8'b00100111,
		ALU_SLL  = 8'b01111100, ALU_SRL  = 8'b00000010, ALU_SRA = 8'b00000011,
		ALU_ADD  = 8'b00100000, ALU_ADDU = 8'b00100001,
		ALU_SUB  = 8'b00100010, ALU_SUBU = 8'b00100011,
		ALU_SLT  = 8'b00101010, ALU_SLTU = 8'b00101011,
		ALU_ADDI = 8'b01010101, ALU_ADDIU = 8'b01010110,
		ALU_LW   = 8'b11100011, ALU_SW   = 8'b11101011,
		ALU_J    = 8'b01001111, ALU_JAL  = 8'b01010000,
		ALU_JR   = 8'b00001000, ALU_JALR = 8'b00001001,
		ALU_BEQ  = 8'b01010001, ALU_BNE  = 8'b01010010,
		ALU_BGTZ = 8'b01010100, ALU_BLEZ = 8'b01010011,
		ALU_BGEZ = 8'b01000001, ALU_BLTZ = 8'b01000000
	} aluop_e;

	typedef enum logic [alusel_w-1:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alusel_e;

	typedef struct packed {
		word_t pc;
		word_t inst;
		logic  in_delayslot;
	} if_id_t;

	// write-back intent of a later stage
	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
		aluop_e    aluop;
	} fwd_t;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		logic      reg1_read;
		logic      reg2_read;
		reg_addr_t reg1_addr;
		reg_addr_t reg2_addr;
		reg_addr_t wd;
		logic      wreg;
		word_t     imm;
	} decode_t;

	typedef struct packed {
		logic  flag;
		word_t target;
		logic  next_in_delayslot;
	} branch_t;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		word_t     link_addr;
		logic      in_delayslot;
		word_t     inst;
	} id_ex_t;

	localparam id_ex_t id_ex_bubble = '{
		aluop: ALU_NOP, alusel: SEL_NOP, reg1: '0, reg2: '0, wd: '0,
		wreg: 1'b0, link_addr: '0, in_delayslot: 1'b0, inst: '0
	};

endpackage

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  id_pkg::if_id_t  if_id_i,
	output id_pkg::decode_t dec_o
);
	import id_pkg::*;

	opcode_e   op;
	funct_e    funct;
	reg_addr_t rs, rt, rd;
	logic [4:0] shamt;
	logic [15:0] imm16;
	logic      const_shift;

	aluop_e    aluop;
	alusel_e   alusel;
	logic      reg1_read, reg2_read;
	logic      wreg;
	reg_addr_t wd;
	word_t     imm;

	assign op    = opcode_e'(if_id_i.inst[31:26]);
	assign funct = funct_e'(if_id_i.inst[5:0]);
	assign rs    = if_id_i.inst[25:21];
	assign rt    = if_id_i.inst[20:16];
	assign rd    = if_id_i.inst[15:11];
	assign shamt = if_id_i.inst[10:6];
	assign imm16 = if_id_i.inst[15:0];
	assign const_shift = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);

	always_comb begin
		aluop = ALU_NOP;
		reg1_read = 1'b0;
		reg2_read = 1'b0;
		wreg = 1'b0;
		wd = rd;
		imm = '0;
		case (op)
			OP_SPECIAL: begin
				case (funct)
					FN_AND:           aluop = ALU_AND;
					FN_OR:            aluop = ALU_OR;
					FN_XOR:           aluop = ALU_XOR;
					FN_NOR:           aluop = ALU_NOR;
					FN_SLL, FN_SLLV:  aluop = ALU_SLL;
					FN_SRL, FN_SRLV:  aluop = ALU_SRL;
					FN_SRA, FN_SRAV:  aluop = ALU_SRA;
					FN_ADD:           aluop = ALU_ADD;
					FN_ADDU:          aluop = ALU_ADDU;
					FN_SUB:           aluop = ALU_SUB;
					FN_SUBU:          aluop = ALU_SUBU;
					FN_SLT:           aluop = ALU_SLT;
					FN_SLTU:          aluop = ALU_SLTU;
					FN_JR:            aluop = ALU_JR;
					FN_JALR:          aluop = ALU_JALR;
					default:          aluop = ALU_NOP;
				endcase
				// constant shifts need rs == 0, everything else shamt == 0
				if (const_shift ? (rs != '0) : (shamt != '0))
					aluop = ALU_NOP;
				if (aluop != ALU_NOP) begin
					wreg = (aluop != ALU_JR);
					reg1_read = !const_shift;   // shamt goes in as operand 1
					reg2_read = !(aluop inside {ALU_JR, ALU_JALR});
					if (const_shift)
						imm = {27'b0, shamt};
				end
			end
			OP_ANDI:  aluop = ALU_AND;
			OP_ORI:   aluop = ALU_OR;
			OP_XORI:  aluop = ALU_XOR;
			OP_LUI:   aluop = ALU_OR;   // rs is 0, so OR passes imm through
			OP_ADDI:  aluop = ALU_ADDI;
			OP_ADDIU: aluop = ALU_ADDIU;
			OP_SLTI:  aluop = ALU_SLT;
			OP_SLTIU: aluop = ALU_SLTU;
			OP_LW:    aluop = ALU_LW;
			OP_SW: begin
				aluop = ALU_SW;
				reg1_read = 1'b1;
				reg2_read = 1'b1;
			end
			OP_J:     aluop = ALU_J;
			OP_JAL: begin
				aluop = ALU_JAL;
				wreg = 1'b1;
				wd = link_reg;
			end
			OP_BEQ, OP_BNE: begin
				aluop = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				reg1_read = 1'b1;
				reg2_read = 1'b1;
			end
			OP_BGTZ, OP_BLEZ: begin
				aluop = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
				reg1_read = 1'b1;
			end
			OP_REGIMM: begin
				if (rt == 5'b00001)
					aluop = ALU_BGEZ;
				else if (rt == 5'b00000)
					aluop = ALU_BLTZ;
				reg1_read = (aluop != ALU_NOP);
			end
			default: aluop = ALU_NOP;
		endcase

		// I-type ALU ops and LW: rs in, rt out
		if (op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU,
				OP_SLTI, OP_SLTIU, OP_LW}) begin
			reg1_read = 1'b1;
			wreg = 1'b1;
			wd = rt;
		end
		if (op inside {OP_ANDI, OP_ORI, OP_XORI})
			imm = {16'b0, imm16};
		else if (op == OP_LUI)
			imm = {imm16, 16'b0};
		else if (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU})
			imm = {{16{imm16[15]}}, imm16};
	end

	// result class follows from the operation
	always_comb begin
		case (aluop)
			ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: alusel = SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA:          alusel = SEL_SHIFT;
			ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
			ALU_ADDI, ALU_ADDIU:                alusel = SEL_ARITH;
			ALU_LW, ALU_SW:                     alusel = SEL_LOAD_STORE;
			ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ, ALU_BNE,
			ALU_BGTZ, ALU_BLEZ, ALU_BGEZ, ALU_BLTZ: alusel = SEL_JUMP_BRANCH;
			default:                            alusel = SEL_NOP;
		endcase
	end

	assign dec_o = '{
		aluop: aluop, alusel: alusel, reg1_read: reg1_read, reg2_read: reg2_read,
		reg1_addr: rs, reg2_addr: rt, wd: wd, wreg: wreg, imm: imm
	};

endmodule

// File: rtl/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
	input  logic              read_i,
	input  id_pkg::reg_addr_t addr_i,
	input  id_pkg::word_t     rf_data_i,
	input  id_pkg::word_t     imm_i,
	input  id_pkg::fwd_t      ex_fwd_i,
	input  id_pkg::fwd_t      mem_fwd_i,
	output id_pkg::word_t     operand_o,
	output logic              hazard_o
);
	import id_pkg::*;

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
	assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

	// load result not available until after mem
	assign hazard_o = read_i && (ex_fwd_i.aluop == ALU_LW) && (ex_fwd_i.wd == addr_i);

	// value is a don't-care while hazard_o is high
	always_comb begin
		if (!read_i)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = ex_fwd_i.wdata;   // youngest wins
		else if (mem_hit)
			operand_o = mem_fwd_i.wdata;
		else
			operand_o = rf_data_i;
	end

endmodule

// File: rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
	input  id_pkg::decode_t dec_i,
	input  id_pkg::if_id_t  if_id_i,
	input  id_pkg::word_t   reg1_i,
	input  id_pkg::word_t   reg2_i,
	input  logic            stall_i,
	output id_pkg::branch_t branch_o,
	output id_pkg::word_t   link_addr_o
);
	import id_pkg::*;

	word_t pc_plus_4;
	word_t pc_plus_8;
	word_t br_target;
	word_t jmp_target;
	word_t target;
	logic  taken;
	logic  redirect;

	assign pc_plus_4  = if_id_i.pc + word_t'(4);
	assign pc_plus_8  = if_id_i.pc + word_t'(8);
	assign br_target  = pc_plus_4 + {{14{if_id_i.inst[15]}}, if_id_i.inst[15:0], 2'b00};
	assign jmp_target = {pc_plus_4[31:28], if_id_i.inst[25:0], 2'b00};

	always_comb begin
		taken = 1'b0;
		target = br_target;
		case (dec_i.aluop)
			ALU_J, ALU_JAL: begin
				taken = 1'b1;
				target = jmp_target;
			end
			ALU_JR, ALU_JALR: begin
				taken = 1'b1;
				target = reg1_i;
			end
			ALU_BEQ:  taken = (reg1_i == reg2_i);
			ALU_BNE:  taken = (reg1_i != reg2_i);
			ALU_BGTZ: taken = !reg1_i[31] && (reg1_i != '0);
			ALU_BLEZ: taken = reg1_i[31] || (reg1_i == '0);
			ALU_BGEZ: taken = !reg1_i[31];
			ALU_BLTZ: taken = reg1_i[31];
			default:  taken = 1'b0;
		endcase
	end

	// operands are stale during a load-use stall
	assign redirect = taken && !stall_i;

	assign branch_o = '{
		flag: redirect,
		target: redirect ? target : '0,
		next_in_delayslot: redirect
	};

	assign link_addr_o = (dec_i.aluop inside {ALU_JAL, ALU_JALR}) ? pc_plus_8 : '0;

endmodule

// File: rtl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            stall_i,
	input  id_pkg::decode_t dec_i,
	input  id_pkg::word_t   reg1_i,
	input  id_pkg::word_t   reg2_i,
	input  id_pkg::word_t   link_addr_i,
	input  id_pkg::if_id_t  if_id_i,
	output id_pkg::id_ex_t  id_ex_o
);
	import id_pkg::*;

	id_ex_t slot;

	assign slot = '{
		aluop: dec_i.aluop,
		alusel: dec_i.alusel,
		reg1: reg1_i,
		reg2: reg2_i,
		wd: dec_i.wd,
		wreg: dec_i.wreg,
		link_addr: link_addr_i,
		in_delayslot: if_id_i.in_delayslot,
		inst: if_id_i.inst
	};

	always_ff @(posedge clk) begin
		if (reset_i || stall_i)
			id_ex_o <= id_ex_bubble;   // bubble into execute
		else
			id_ex_o <= slot;
	end

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
	input  logic              clk,
	input  logic              reset_i,
	input  id_pkg::if_id_t    if_id_i,
	input  id_pkg::fwd_t      ex_fwd_i,
	input  id_pkg::fwd_t      mem_fwd_i,
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,
	output logic              reg1_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output id_pkg::branch_t   branch_o,
	output logic              stall_req_o,
	output id_pkg::id_ex_t    id_ex_o
);
	import id_pkg::*;

	decode_t dec;
	word_t   reg1;
	word_t   reg2;
	word_t   link_addr;
	logic    hazard1;
	logic    hazard2;

	assign reg1_read_o = dec.reg1_read;
	assign reg1_addr_o = dec.reg1_addr;
	assign reg2_read_o = dec.reg2_read;
	assign reg2_addr_o = dec.reg2_addr;
	assign stall_req_o = hazard1 | hazard2;

	inst_decoder u_dec (
		.if_id_i (if_id_i),
		.dec_o   (dec)
	);

	operand_forward u_fwd1 (
		.read_i    (dec.reg1_read),
		.addr_i    (dec.reg1_addr),
		.rf_data_i (reg1_data_i),
		.imm_i     (dec.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (reg1),
		.hazard_o  (hazard1)
	);

	operand_forward u_fwd2 (
		.read_i    (dec.reg2_read),
		.addr_i    (dec.reg2_addr),
		.rf_data_i (reg2_data_i),
		.imm_i     (dec.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (reg2),
		.hazard_o  (hazard2)
	);

	branch_unit u_branch (
		.dec_i       (dec),
		.if_id_i     (if_id_i),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.stall_i     (stall_req_o),
		.branch_o    (branch_o),
		.link_addr_o (link_addr)
	);

	id_ex_reg u_id_ex (
		.clk         (clk),
		.reset_i     (reset_i),
		.stall_i     (stall_req_o),
		.dec_i       (dec),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.link_addr_i (link_addr),
		.if_id_i     (if_id_i),
		.id_ex_o     (id_ex_o)
	);

endmodule

// File: tests/id_stage_asserts.sv
`timescale 1ns/1ps

module id_stage_asserts (
	input logic            clk_i,
	input logic            reset_i,
	input logic            stall_i,
	input id_pkg::branch_t branch_i,
	input id_pkg::id_ex_t  id_ex_i
);

	int unsigned fail_count = 0;   // read by the testbench

	// load-use stall puts a bubble into execute
	a_stall_bubble: assert property (@(posedge clk_i) disable iff (reset_i)
		stall_i |=> !id_ex_i.wreg)
	else begin
		fail_count++;
		$error("stall not followed by a bubble");
	end

	a_no_redirect_in_stall: assert property (@(posedge clk_i) disable iff (reset_i)
		!(branch_i.flag && stall_i))
	else begin
		fail_count++;
		$error("branch taken during a stall");
	end

	a_delayslot: assert property (@(posedge clk_i) disable iff (reset_i)
		branch_i.flag == branch_i.next_in_delayslot)
	else begin
		fail_count++;
		$error("next_in_delayslot differs from branch flag");
	end

endmodule

bind id_stage id_stage_asserts u_asserts (
	.clk_i    (clk),
	.reset_i  (reset_i),
	.stall_i  (stall_req_o),
	.branch_i (branch_o),
	.id_ex_i  (id_ex_o)
);

// File: tests/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
	import id_pkg::*;

	typedef struct packed {
		if_id_t  if_id;
		fwd_t    ex;
		fwd_t    mem;
		word_t   d1;
		word_t   d2;
		logic    en1;
		logic    en2;
		branch_t br;
		logic    stall;
		id_ex_t  exp;
	} row_t;

	logic clk;
	logic reset;
	if_id_t if_id;
	fwd_t ex_fwd, mem_fwd;
	word_t reg1_data, reg2_data;
	logic reg1_read, reg2_read, stall_req;
	reg_addr_t reg1_addr, reg2_addr;
	branch_t branch;
	id_ex_t id_ex;

	row_t rows[$];
	word_t cur_pc = 32'h4000_1000;
	logic cur_ds = 1'b0;
	fwd_t nofwd = '0;
	branch_t nobr = '0;
	int ctrl_errs = 0, branch_errs = 0, id_ex_errs = 0;
	int cycles = 0;

	id_stage u_dut (
		.clk(clk), .reset_i(reset), .if_id_i(if_id), .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd),
		.reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
		.reg1_read_o(reg1_read), .reg1_addr_o(reg1_addr),
		.reg2_read_o(reg2_read), .reg2_addr_o(reg2_addr),
		.branch_o(branch), .stall_req_o(stall_req), .id_ex_o(id_ex)
	);

	function automatic word_t r_inst(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
			logic [4:0] sh, funct_e fn);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t i_inst(opcode_e op, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic fwd_t producer(logic we, reg_addr_t wd, word_t data, aluop_e op);
		return '{wreg: we, wd: wd, wdata: data, aluop: op};
	endfunction

	function automatic branch_t jump_to(word_t target);
		return '{flag: 1'b1, target: target, next_in_delayslot: 1'b1};
	endfunction

	// inst and in_delayslot are filled in by add_row
	function automatic id_ex_t slot_of(aluop_e op, alusel_e sel, word_t r1, word_t r2,
			reg_addr_t wd, logic we, word_t link);
		return '{op, sel, r1, r2, wd, we, link, 1'b0, 32'h0};
	endfunction

	task automatic add_row(word_t inst, fwd_t ex, fwd_t mem, word_t d1, word_t d2,
			logic en1, logic en2, branch_t br, logic stall, id_ex_t exp);
		row_t r;
		r.if_id = '{pc: cur_pc, inst: inst, in_delayslot: cur_ds};
		r.ex = ex;
		r.mem = mem;
		r.d1 = d1;
		r.d2 = d2;
		r.en1 = en1;
		r.en2 = en2;
		r.br = br;
		r.stall = stall;
		if (!stall) begin   // a stalled slot leaves as a bubble
			exp.inst = inst;
			exp.in_delayslot = cur_ds;
		end
		r.exp = exp;
		rows.push_back(r);
	endtask

	task automatic branch_row(aluop_e op, word_t inst, word_t d1, word_t d2, logic two,
			logic taken, word_t target);
		add_row(inst, nofwd, nofwd, d1, d2, 1'b1, two, taken ? jump_to(target) : nobr, 1'b0,
			slot_of(op, SEL_JUMP_BRANCH, d1, two ? d2 : 32'h0, 5'd0, 1'b0, 32'h0));
	endtask

	task automatic check_ctrl(logic stall, logic rd1, reg_addr_t a1, logic rd2, reg_addr_t a2,
			logic e_stall, logic e_rd1, reg_addr_t e_a1, logic e_rd2, reg_addr_t e_a2);
		if (stall !== e_stall || rd1 !== e_rd1 || rd2 !== e_rd2 ||
				(e_rd1 && a1 !== e_a1) || (e_rd2 && a2 !== e_a2)) begin
			ctrl_errs++;
			$display("** Error at %0t: stall/rd1/a1/rd2/a2 %b %b %0d %b %0d, expected %b %b %0d %b %0d",
				$time, stall, rd1, a1, rd2, a2, e_stall, e_rd1, e_a1, e_rd2, e_a2);
		end
	endtask

	task automatic check_branch(branch_t got, branch_t exp);
		branch_t e;
		e = exp;
		if (!e.flag)
			e.target = got.target;   // target only matters when taken
		if (got !== e) begin
			branch_errs++;
			$display("** Error at %0t: branch_o %h, expected %h", $time, got, e);
		end
	endtask

	task automatic check_id_ex(id_ex_t got, id_ex_t exp);
		id_ex_t e;
		e = exp;
		if (!e.wreg)
			e.wd = got.wd;   // destination unused without a write
		if (got !== e) begin
			id_ex_errs++;
			$display("** Error at %0t: id_ex_o %h, expected %h", $time, got, e);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= 5 + 2 * rows.size() + 20) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		word_t w0, w1, w2, w3;
		int total;
		w0 = $urandom(32'h8fe3);
		w1 = $urandom;
		w2 = $urandom;
		w3 = $urandom;
		reset = 1'b1;
		if_id = '{pc: cur_pc, inst: r_inst(1, 2, 3, 0, FN_ADD), in_delayslot: 1'b1};
		ex_fwd = nofwd;
		mem_fwd = nofwd;
		reg1_data = w0;
		reg2_data = w1;

		cur_ds = 1'b1;
		add_row(r_inst(1, 2, 3, 0, FN_ADD), nofwd, nofwd, w0, w1, 1, 1, nobr, 0,
			slot_of(ALU_ADD, SEL_ARITH, w0, w1, 3, 1, 0));
		cur_ds = 1'b0;
		add_row(r_inst(5, 6, 4, 0, FN_OR), nofwd, nofwd, w0, w1, 1, 1, nobr, 0,
			slot_of(ALU_OR, SEL_LOGIC, w0, w1, 4, 1, 0));
		add_row(r_inst(1, 2, 7, 0, FN_SRAV), nofwd, nofwd, w0, w1, 1, 1, nobr, 0,
			slot_of(ALU_SRA, SEL_SHIFT, w0, w1, 7, 1, 0));
		add_row(r_inst(0, 2, 8, 5, FN_SLL), nofwd, nofwd, w0, w1, 0, 1, nobr, 0,
			slot_of(ALU_SLL, SEL_SHIFT, 32'd5, w1, 8, 1, 0));
		add_row(i_inst(OP_ORI, 1, 9, 16'h8001), nofwd, nofwd, w0, w1, 1, 0, nobr, 0,
			slot_of(ALU_OR, SEL_LOGIC, w0, 32'h0000_8001, 9, 1, 0));
		add_row(i_inst(OP_ANDI, 1, 10, 16'hf0f0), nofwd, nofwd, w0, w1, 1, 0, nobr, 0,
			slot_of(ALU_AND, SEL_LOGIC, w0, 32'h0000_f0f0, 10, 1, 0));
		add_row(i_inst(OP_LUI, 0, 11, 16'h1234), nofwd, nofwd, 32'h0, w1, 1, 0, nobr, 0,
			slot_of(ALU_OR, SEL_LOGIC, 32'h0, 32'h1234_0000, 11, 1, 0));
		add_row(i_inst(OP_ADDI, 1, 12, 16'hfffc), nofwd, nofwd, w0, w1, 1, 0, nobr, 0,
			slot_of(ALU_ADDI, SEL_ARITH, w0, 32'hffff_fffc, 12, 1, 0));
		add_row(i_inst(OP_SLTI, 1, 13, 16'h8000), nofwd, nofwd, w0, w1, 1, 0, nobr, 0,
			slot_of(ALU_SLT, SEL_ARITH, w0, 32'hffff_8000, 13, 1, 0));
		// forwarding, execute over memory over register file
		add_row(r_inst(1, 2, 3, 0, FN_ADD), producer(1, 1, w2, ALU_ADD),
			producer(1, 1, w3, ALU_ADD), w0, w1, 1, 1, nobr, 0,
			slot_of(ALU_ADD, SEL_ARITH, w2, w1, 3, 1, 0));
		add_row(r_inst(1, 2, 3, 0, FN_ADD), producer(1, 1, w2, ALU_ADDU),
			producer(1, 2, w3, ALU_OR), w0, w1, 1, 1, nobr, 0,
			slot_of(ALU_ADD, SEL_ARITH, w2, w3, 3, 1, 0));
		add_row(i_inst(OP_ORI, 1, 9, 16'h00ff), producer(1, 9, w2, ALU_ADD), nofwd,
			w0, w1, 1, 0, nobr, 0, slot_of(ALU_OR, SEL_LOGIC, w0, 32'h0000_00ff, 9, 1, 0));
		// load-use
		add_row(r_inst(1, 2, 3, 0, FN_ADD), producer(1, 2, w2, ALU_LW), nofwd,
			w0, w1, 1, 1, nobr, 1, slot_of(ALU_NOP, SEL_NOP, 0, 0, 0, 0, 0));
		add_row(i_inst(OP_BEQ, 1, 2, 16'h0010), producer(1, 1, 32'd5, ALU_LW), nofwd,
			32'd5, 32'd5, 1, 1, nobr, 1, slot_of(ALU_NOP, SEL_NOP, 0, 0, 0, 0, 0));
		branch_row(ALU_BEQ, i_inst(OP_BEQ, 1, 2, 16'h0010), 5, 5, 1, 1, 32'h4000_1044);
		branch_row(ALU_BEQ, i_inst(OP_BEQ, 1, 2, 16'h0010), 5, 6, 1, 0, 0);
		branch_row(ALU_BNE, i_inst(OP_BNE, 1, 2, 16'hfff0), 5, 6, 1, 1, 32'h4000_0fc4);
		branch_row(ALU_BNE, i_inst(OP_BNE, 1, 2, 16'hfff0), 5, 5, 1, 0, 0);
		branch_row(ALU_BGTZ, i_inst(OP_BGTZ, 1, 0, 16'h0010), 1, w1, 0, 1, 32'h4000_1044);
		branch_row(ALU_BGTZ, i_inst(OP_BGTZ, 1, 0, 16'h0010), 0, w1, 0, 0, 0);
		branch_row(ALU_BLEZ, i_inst(OP_BLEZ, 1, 0, 16'hfff0), 32'h8000_0000, w1, 0, 1,
			32'h4000_0fc4);
		branch_row(ALU_BLEZ, i_inst(OP_BLEZ, 1, 0, 16'hfff0), 0, w1, 0, 1, 32'h4000_0fc4);
		branch_row(ALU_BLEZ, i_inst(OP_BLEZ, 1, 0, 16'hfff0), 32'h7fff_ffff, w1, 0, 0, 0);
		branch_row(ALU_BGEZ, i_inst(OP_REGIMM, 1, 1, 16'h0010), 0, w1, 0, 1, 32'h4000_1044);
		branch_row(ALU_BGEZ, i_inst(OP_REGIMM, 1, 1, 16'h0010), 32'hffff_ffff, w1, 0, 0, 0);
		branch_row(ALU_BLTZ, i_inst(OP_REGIMM, 1, 0, 16'h0010), 32'h8000_0000, w1, 0, 1,
			32'h4000_1044);
		branch_row(ALU_BLTZ, i_inst(OP_REGIMM, 1, 0, 16'h0010), 0, w1, 0, 0, 0);
		// jumps, region of pc+4 is 4
		add_row({OP_J, 26'h2abcdef}, nofwd, nofwd, w0, w1, 0, 0, jump_to(32'h4aaf_37bc), 0,
			slot_of(ALU_J, SEL_JUMP_BRANCH, 0, 0, 0, 0, 0));
		add_row({OP_JAL, 26'h2abcdef}, nofwd, nofwd, w0, w1, 0, 0, jump_to(32'h4aaf_37bc), 0,
			slot_of(ALU_JAL, SEL_JUMP_BRANCH, 0, 0, 31, 1, 32'h4000_1008));
		add_row(r_inst(5, 0, 0, 0, FN_JR), nofwd, nofwd, 32'h0040_0100, w1, 1, 0,
			jump_to(32'h0040_0100), 0,
			slot_of(ALU_JR, SEL_JUMP_BRANCH, 32'h0040_0100, 0, 0, 0, 0));
		add_row(r_inst(5, 0, 31, 0, FN_JALR), nofwd, nofwd, 32'h0040_0100, w1, 1, 0,
			jump_to(32'h0040_0100), 0,
			slot_of(ALU_JALR, SEL_JUMP_BRANCH, 32'h0040_0100, 0, 31, 1, 32'h4000_1008));

		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_id_ex(id_ex, slot_of(ALU_NOP, SEL_NOP, 0, 0, 0, 0, 0));

		// id_ex_o of row i is checked one edge after it was driven
		for (int i = 0; i <= rows.size(); i++) begin
			@(posedge clk);
			if (i < rows.size()) begin
				if_id <= rows[i].if_id;
				ex_fwd <= rows[i].ex;
				mem_fwd <= rows[i].mem;
				reg1_data <= rows[i].d1;
				reg2_data <= rows[i].d2;
			end
			@(negedge clk);
			if (i < rows.size()) begin
				check_ctrl(stall_req, reg1_read, reg1_addr, reg2_read, reg2_addr,
					rows[i].stall, rows[i].en1, rows[i].if_id.inst[25:21],
					rows[i].en2, rows[i].if_id.inst[20:16]);
				check_branch(branch, rows[i].br);
			end
			if (i > 0)
				check_id_ex(id_ex, rows[i-1].exp);
		end

		total = ctrl_errs + branch_errs + id_ex_errs + u_dut.u_asserts.fail_count;
		$display("errors: ctrl %0d, branch %0d, id_ex %0d, assertions %0d",
			ctrl_errs, branch_errs, id_ex_errs, u_dut.u_asserts.fail_count);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: sources.f
common/id_pkg.sv
rtl/inst_decoder.sv
rtl/operand_forward.sv
rtl/branch_unit.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
tests/id_stage_asserts.sv
tests/tb_id_stage.sv
